// ==== src/hamming_pkg.sv ====
package hamming_pkg;

    // Element codeword (15,11)
    localparam int elem_data_w = 11;
    localparam int elem_code_w = 15;

    // Mode codeword (9,5)
    localparam int mode_data_w = 5;
    localparam int mode_code_w = 9;

    // Decoded mode values that select a computation
    localparam logic [mode_data_w-1:0] mode_code_2x2 = 5'b00100;
    localparam logic [mode_data_w-1:0] mode_code_3x3 = 5'b00110;

endpackage

// ==== src/det_pkg.sv ====
package det_pkg;

    // ========================================
    // Matrix geometry
    // ========================================
    localparam int mat_dim    = 4;
    localparam int elem_count = mat_dim * mat_dim;
    localparam int idx_w      = 4;

    // Elements are the corrected Hamming payload, read as signed
    typedef logic signed [hamming_pkg::elem_data_w-1:0] elem_t;

    // ========================================
    // Result fields
    // ========================================
    localparam int det2_w = 23;
    localparam int det3_w = 51;
    localparam int n_det2 = 9;
    localparam int n_det3 = 4;
    localparam int out_w  = 207;
    localparam int slot_w = 4;

    typedef enum logic [1:0] {
        mode_2x2,
        mode_3x3,
        mode_none
    } det_mode_e;

    typedef logic signed [det2_w-1:0] det2_t;
    typedef logic signed [det3_w-1:0] det3_t;

    // Widest field, carries both sizes between engine and packer
    typedef det3_t field_t;

    // Slot 0 sits in the top field of either layout
    typedef struct packed {
        det2_t [n_det2-1:0] f;
    } det2_layout_t;

    typedef struct packed {
        logic  [out_w-n_det3*det3_w-1:0] pad;
        det3_t [n_det3-1:0]              f;
    } det3_layout_t;

    typedef union packed {
        det2_layout_t l2;
        det3_layout_t l3;
    } det_word_u;

endpackage

// ==== src/det_if.sv ====
`timescale 1ns/10ps

// Element stream, input decoder to engine
interface elem_if;
    logic                      valid;
    logic [det_pkg::idx_w-1:0] index;
    det_pkg::elem_t            value;
    // Only meaningful alongside index 0
    det_pkg::det_mode_e        mode;

    modport source (
        output valid,
        output index,
        output value,
        output mode
    );

    modport sink (
        input valid,
        input index,
        input value,
        input mode
    );
endinterface

// Field stream, engine to result packer
interface field_if;
    logic                       valid;
    logic [det_pkg::slot_w-1:0] slot;
    det_pkg::field_t            value;
    det_pkg::det_mode_e         mode;
    logic                       last;

    modport source (
        output valid,
        output slot,
        output value,
        output mode,
        output last
    );

    modport sink (
        input valid,
        input slot,
        input value,
        input mode,
        input last
    );
endinterface

// ==== src/hamming_corrector.sv ====
`timescale 1ns/10ps

module hamming_corrector #(
    parameter  int data_w = 11,
    localparam int par_w  = $clog2(data_w + $clog2(data_w) + 1),
    localparam int code_w = data_w + par_w
) (
    input  logic [code_w-1:0] code,
    output logic [data_w-1:0] data
);

    logic [par_w-1:0]  syndrome;
    logic [code_w-1:0] fixed;

    // Position 1 is the MSB, position code_w the LSB
    always_comb begin
        int k;
        syndrome = '0;
        for (int p = 1; p <= code_w; p++) begin
            if (code[code_w-p]) begin
                syndrome ^= par_w'(p);
            end
        end

        // Flip the bit the syndrome points at
        fixed = code;
        if (syndrome != '0 && syndrome <= code_w) begin
            fixed[code_w-syndrome] = ~fixed[code_w-syndrome];
        end

        // Collect non-power-of-two positions, MSB first
        k = data_w;
        data = '0;
        for (int p = 1; p <= code_w; p++) begin
            if ((p & (p - 1)) != 0) begin
                k = k - 1;
                data[k] = fixed[code_w-p];
            end
        end
    end

endmodule

// ==== src/det_input_decode.sv ====
`timescale 1ns/10ps

module det_input_decode (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic [hamming_pkg::elem_code_w-1:0] in_data,
    input  logic [hamming_pkg::mode_code_w-1:0] in_mode,
    elem_if.source                              elem
);

    logic [hamming_pkg::elem_data_w-1:0] elem_data;
    logic [hamming_pkg::mode_data_w-1:0] mode_data;
    logic [det_pkg::idx_w-1:0]           cnt;
    det_pkg::det_mode_e                  mode_dec;

    // ========================================
    // Single-error correction
    // ========================================
    hamming_corrector #(
        .data_w (hamming_pkg::elem_data_w)
    ) u_elem_fix (
        .code (in_data),
        .data (elem_data)
    );

    hamming_corrector #(
        .data_w (hamming_pkg::mode_data_w)
    ) u_mode_fix (
        .code (in_mode),
        .data (mode_data)
    );

    // Unknown codes fall back to the zero result
    always_comb begin
        case (mode_data)
            hamming_pkg::mode_code_2x2: mode_dec = det_pkg::mode_2x2;
            hamming_pkg::mode_code_3x3: mode_dec = det_pkg::mode_3x3;
            default:                    mode_dec = det_pkg::mode_none;
        endcase
    end

    // ========================================
    // Element counter and strobe
    // ========================================
    // Counter wraps to 0 after the sixteenth element
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= '0;
            elem.valid <= 1'b0;
        end else begin
            elem.valid <= in_valid;
            if (in_valid) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            elem.value <= elem_data;
            elem.index <= cnt;
            // Mode word only travels with the first element
            if (cnt == '0) begin
                elem.mode <= mode_dec;
            end
        end
    end

endmodule

// ==== src/det_engine.sv ====
`timescale 1ns/10ps

module det_engine (
    input  logic    clk,
    input  logic    rst_n,
    elem_if.sink    elem,
    field_if.source field
);

    localparam int win = det_pkg::mat_dim - 1;

    det_pkg::elem_t               mat [det_pkg::elem_count];
    det_pkg::det_mode_e           mode_q;
    logic                         busy;
    logic [det_pkg::slot_w-1:0]   slot_q;
    logic [det_pkg::slot_w-1:0]   last_slot;
    logic                         start;
    logic                         active;
    logic                         at_last;
    logic [det_pkg::idx_w-1:0]    corner2;
    logic [det_pkg::idx_w-1:0]    corner3;
    logic [det_pkg::idx_w-1:0]    corner;
    det_pkg::elem_t               w [win][win];
    det_pkg::det2_t               det2_val;
    det_pkg::det2_t               cof0;
    det_pkg::det2_t               cof1;
    det_pkg::det2_t               cof2;
    det_pkg::field_t              det3_val;
    det_pkg::field_t              field_val;

    // Gives a*d - b*c for 2x2 fields and for the 3x3 cofactors
    function automatic det_pkg::det2_t det2(
        input det_pkg::elem_t a,
        input det_pkg::elem_t b,
        input det_pkg::elem_t c,
        input det_pkg::elem_t d
    );
        return a * d - b * c;
    endfunction

    // ========================================
    // Matrix and mode storage
    // ========================================
    always_ff @(posedge clk) begin
        if (elem.valid) begin
            mat[elem.index] <= elem.value;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q <= det_pkg::mode_none;
        end else if (elem.valid && elem.index == '0) begin
            mode_q <= elem.mode;
        end
    end

    // ========================================
    // Slot sequencing
    // ========================================
    // Slot 0 never needs element 15, so it runs alongside that strobe
    assign start     = elem.valid && (elem.index == det_pkg::idx_w'(det_pkg::elem_count - 1));
    assign active    = start || busy;
    assign last_slot = (mode_q == det_pkg::mode_3x3) ? det_pkg::slot_w'(det_pkg::n_det3 - 1)
                                                     : det_pkg::slot_w'(det_pkg::n_det2 - 1);
    assign at_last   = (slot_q == last_slot);

    // Slot counter rests at 0 between matrices
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            slot_q <= '0;
        end else if (active) begin
            busy   <= !at_last;
            slot_q <= at_last ? '0 : slot_q + 1'b1;
        end
    end

    // ========================================
    // Field arithmetic
    // ========================================
    // Top-left corner of the submatrix in row-major corner order
    assign corner2 = det_pkg::idx_w'((slot_q / (det_pkg::mat_dim - 1)) * det_pkg::mat_dim
                                     + slot_q % (det_pkg::mat_dim - 1));
    assign corner3 = det_pkg::idx_w'((slot_q / (det_pkg::mat_dim - 2)) * det_pkg::mat_dim
                                     + slot_q % (det_pkg::mat_dim - 2));
    assign corner  = (mode_q == det_pkg::mode_3x3) ? corner3 : corner2;

    // 3x3 window at the corner; the 2x2 case reads its top-left part
    always_comb begin
        for (int r = 0; r < win; r++) begin
            for (int c = 0; c < win; c++) begin
                w[r][c] = mat[det_pkg::idx_w'(corner + r * det_pkg::mat_dim + c)];
            end
        end
    end

    assign det2_val = det2(w[0][0], w[0][1], w[1][0], w[1][1]);

    // First-row cofactor expansion
    assign cof0     = det2(w[1][1], w[1][2], w[2][1], w[2][2]);
    assign cof1     = det2(w[1][0], w[1][2], w[2][0], w[2][2]);
    assign cof2     = det2(w[1][0], w[1][1], w[2][0], w[2][1]);
    assign det3_val = w[0][0] * cof0 - w[0][1] * cof1 + w[0][2] * cof2;

    always_comb begin
        case (mode_q)
            det_pkg::mode_2x2: field_val = det2_val;
            det_pkg::mode_3x3: field_val = det3_val;
            default:           field_val = '0;
        endcase
    end

    // ========================================
    // Field output
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            field.valid <= 1'b0;
            field.last  <= 1'b0;
        end else begin
            field.valid <= active;
            field.last  <= active && at_last;
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            field.slot  <= slot_q;
            field.value <= field_val;
            field.mode  <= mode_q;
        end
    end

endmodule

// ==== src/det_result_pack.sv ====
`timescale 1ns/10ps

module det_result_pack (
    input  logic                      clk,
    input  logic                      rst_n,
    field_if.sink                     field,
    output logic                      out_valid,
    output logic [det_pkg::out_w-1:0] out_data
);

    det_pkg::det_word_u word_q;
    det_pkg::det_word_u word_d;
    logic               done;

    assign done = field.valid && field.last;

    // ========================================
    // Field placement
    // ========================================
    // Pad bits of the 3x3 layout stay at zero from the cleared word
    always_comb begin
        word_d = word_q;
        if (field.valid) begin
            if (field.mode == det_pkg::mode_3x3) begin
                word_d.l3.f[det_pkg::n_det3 - 1 - field.slot] = field.value;
            end else begin
                word_d.l2.f[det_pkg::n_det2 - 1 - field.slot] =
                    field.value[det_pkg::det2_w-1:0];
            end
        end
    end

    // ========================================
    // Output register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_q    <= '0;
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= done;
            if (done) begin
                out_data <= word_d;
                word_q   <= '0;
            end else begin
                // Output held at zero between results
                out_data <= '0;
                word_q   <= word_d;
            end
        end
    end

endmodule

// ==== src/mdc_top.sv ====
`timescale 1ns/10ps

module mdc_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic [hamming_pkg::elem_code_w-1:0] in_data,
    input  logic [hamming_pkg::mode_code_w-1:0] in_mode,
    output logic                                out_valid,
    output logic [det_pkg::out_w-1:0]           out_data
);

    elem_if  elem_bus ();
    field_if field_bus ();

    // Correction, element count and strobes
    det_input_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_mode  (in_mode),
        .elem     (elem_bus.source)
    );

    // Matrix store and one field per cycle
    det_engine u_engine (
        .clk   (clk),
        .rst_n (rst_n),
        .elem  (elem_bus.sink),
        .field (field_bus.source)
    );

    // Word assembly and out_valid pulse
    det_result_pack u_pack (
        .clk       (clk),
        .rst_n     (rst_n),
        .field     (field_bus.sink),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== verification/mdc_ref_model.svh ====
`ifndef MDC_REF_MODEL_SVH
`define MDC_REF_MODEL_SVH

// Parity bits needed for single-error correction
function automatic int parity_bits(input int data_w);
    int r;
    r = 0;
    while ((1 << r) < data_w + r + 1) begin
        r++;
    end
    return r;
endfunction

// Codeword is right-aligned, position 1 is its MSB
function automatic logic [14:0] hamming_encode(input logic [10:0] data, input int data_w);
    int          n;
    int          k;
    logic        par;
    logic [14:0] code;
    n    = data_w + parity_bits(data_w);
    code = '0;
    k    = data_w;
    // Payload into the non-power-of-two positions, MSB first
    for (int p = 1; p <= n; p++) begin
        if ((p & (p - 1)) != 0) begin
            k--;
            code[n-p] = data[k];
        end
    end
    // Parity bit i covers every position with bit i set
    for (int i = 0; (1 << i) <= n; i++) begin
        par = 1'b0;
        for (int p = 1; p <= n; p++) begin
            if (((p >> i) & 1) != 0 && p != (1 << i)) begin
                par ^= code[n-p];
            end
        end
        code[n-(1 << i)] = par;
    end
    return code;
endfunction

// One random bit error within the lower n bits
function automatic logic [14:0] flip_one_bit(input logic [14:0] code, input int n);
    return code ^ (15'd1 << ($urandom % n));
endfunction

function automatic longint det2_at(input longint m [16], input int r, input int c);
    int d;
    d = det_pkg::mat_dim;
    return m[r*d+c] * m[(r+1)*d+c+1] - m[r*d+c+1] * m[(r+1)*d+c];
endfunction

// Rule of Sarrus on the 3x3 window at (r, c)
function automatic longint det3_at(input longint m [16], input int r, input int c);
    longint a [3][3];
    for (int i = 0; i < 3; i++) begin
        for (int j = 0; j < 3; j++) begin
            a[i][j] = m[(r+i)*det_pkg::mat_dim + c + j];
        end
    end
    return a[0][0]*a[1][1]*a[2][2] + a[0][1]*a[1][2]*a[2][0] + a[0][2]*a[1][0]*a[2][1]
         - a[0][2]*a[1][1]*a[2][0] - a[0][0]*a[1][2]*a[2][1] - a[0][1]*a[1][0]*a[2][2];
endfunction

// Slot 0 lands in the top field, fields are two's complement
function automatic logic [det_pkg::out_w-1:0] expected_word(
    input longint                            m [16],
    input logic [hamming_pkg::mode_data_w-1:0] mode
);
    logic [det_pkg::out_w-1:0] word;
    logic [det_pkg::out_w-1:0] wide;
    logic [63:0]               bits;
    word = '0;
    if (mode == hamming_pkg::mode_code_2x2) begin
        for (int s = 0; s < det_pkg::n_det2; s++) begin
            bits       = 64'(det2_at(m, s / 3, s % 3)) & ((64'd1 << det_pkg::det2_w) - 1);
            wide       = '0;
            wide[63:0] = bits;
            word |= wide << (det_pkg::out_w - det_pkg::det2_w * (s + 1));
        end
    end else if (mode == hamming_pkg::mode_code_3x3) begin
        for (int s = 0; s < det_pkg::n_det3; s++) begin
            bits       = 64'(det3_at(m, s / 2, s % 2)) & ((64'd1 << det_pkg::det3_w) - 1);
            wide       = '0;
            wide[63:0] = bits;
            word |= wide << (det_pkg::det3_w * (det_pkg::n_det3 - 1 - s));
        end
    end
    return word;
endfunction

`endif

// ==== verification/mdc_tb.sv ====
`timescale 1ns/10ps

module mdc_tb;

    localparam int clk_period    = 100;
    localparam int reset_cycles  = 16;
    localparam int n_planned     = 20;
    localparam int result_wait   = 20;

    logic                                clk = 1'b0;
    logic                                rst_n;
    logic                                in_valid;
    logic [hamming_pkg::elem_code_w-1:0] in_data;
    logic [hamming_pkg::mode_code_w-1:0] in_mode;
    logic                                out_valid;
    logic [det_pkg::out_w-1:0]           out_data;

    logic [det_pkg::out_w-1:0] exp_word = '0;
    int                        expect_at = -1;
    int                        cyc = 0;
    int                        n_errors = 0;
    int                        n_matrices = 0;
    int                        n_results = 0;
    longint                    mat [16];

    `include "mdc_ref_model.svh"

    mdc_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #(clk_period / 2) clk = ~clk;

    // Posedge count, the reference for result latency
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ========================================
    // Output protocol checks
    // ========================================
    a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_data == '0)
        else begin
            n_errors++;
            $display("FAIL t=%0t out_data exp=0 got=%h", $time, $sampled(out_data));
        end

    a_pulse: assert property (@(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid)
        else begin
            n_errors++;
            $display("FAIL t=%0t out_valid exp=0 got=1", $time);
        end

    a_on_time: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> cyc == expect_at)
        else begin
            n_errors++;
            $display("FAIL t=%0t out_valid cycle exp=%0d got=%0d",
                     $time, $sampled(expect_at), $sampled(cyc));
        end

    a_not_late: assert property (@(posedge clk) disable iff (!rst_n)
        cyc == expect_at |-> out_valid)
        else begin
            n_errors++;
            $display("FAIL t=%0t out_valid exp=1 got=0", $time);
        end

    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_data == exp_word)
        else begin
            n_errors++;
            $display("FAIL t=%0t out_data exp=%h got=%h",
                     $time, $sampled(exp_word), $sampled(out_data));
        end

    // ========================================
    // Stimulus helpers
    // ========================================
    task automatic check_reset_value(input string name, input logic [det_pkg::out_w-1:0] got);
        a_reset_zero: assert (got === '0)
            else begin
                n_errors++;
                $display("FAIL t=%0t %s exp=0 got=%h", $time, name, got);
            end
    endtask

    function automatic logic [hamming_pkg::mode_data_w-1:0] unknown_mode_code();
        logic [hamming_pkg::mode_data_w-1:0] m;
        m = 5'($urandom);
        while (m == hamming_pkg::mode_code_2x2 || m == hamming_pkg::mode_code_3x3) begin
            m = 5'($urandom);
        end
        return m;
    endfunction

    // One matrix in, then wait for its result
    task automatic run_matrix(input logic [hamming_pkg::mode_data_w-1:0] mode_word,
                              input bit flip_elems, input bit flip_mode, input bit extremes);
        logic [14:0] code;
        logic [14:0] mcode;
        logic [10:0] raw;
        int          lat;
        int          waited;
        bit          seen;
        for (int k = 0; k < det_pkg::elem_count; k++) begin
            if (extremes) begin
                raw = ($urandom % 2) ? 11'h400 : 11'h3ff;
            end else begin
                raw = 11'($urandom);
            end
            mat[k] = longint'($signed(raw));
        end
        lat = (mode_word == hamming_pkg::mode_code_3x3) ? 6 : 11;
        for (int k = 0; k < det_pkg::elem_count; k++) begin
            @(negedge clk);
            code = hamming_encode(11'(mat[k]), hamming_pkg::elem_data_w);
            if (flip_elems) begin
                code = flip_one_bit(code, hamming_pkg::elem_code_w);
            end
            if (k == 0) begin
                mcode = hamming_encode({6'b0, mode_word}, hamming_pkg::mode_data_w);
                if (flip_mode) begin
                    mcode = flip_one_bit(mcode, hamming_pkg::mode_code_w);
                end
                in_mode = mcode[hamming_pkg::mode_code_w-1:0];
            end else begin
                // Mode input is ignored past the first element
                in_mode = 9'($urandom);
            end
            if (k == det_pkg::elem_count - 1) begin
                exp_word  = expected_word(mat, mode_word);
                expect_at = cyc + lat;
            end
            in_valid = 1'b1;
            in_data  = code;
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_data  = 15'($urandom);
        seen     = 1'b0;
        for (waited = 0; waited < result_wait && !seen; waited++) begin
            @(negedge clk);
            seen = out_valid;
        end
        a_result_seen: assert (seen)
            else begin
                n_errors++;
                $display("No out_valid within %0d cycles after the last element", result_wait);
            end
        if (seen) begin
            n_results++;
        end
        n_matrices++;
        @(negedge clk);
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        void'($urandom(32'hbf8c7176));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        in_mode  = '0;
        repeat (reset_cycles) begin
            @(negedge clk);
            check_reset_value("out_valid", det_pkg::out_w'(out_valid));
            check_reset_value("out_data", out_data);
            check_reset_value("elem strobe", det_pkg::out_w'(DUT.elem_bus.valid));
            check_reset_value("field strobe", det_pkg::out_w'(DUT.field_bus.valid));
        end
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        // Clean 2x2 and 3x3, random then full-scale values
        repeat (4) run_matrix(hamming_pkg::mode_code_2x2, 1'b0, 1'b0, 1'b0);
        run_matrix(hamming_pkg::mode_code_2x2, 1'b0, 1'b0, 1'b1);
        repeat (4) run_matrix(hamming_pkg::mode_code_3x3, 1'b0, 1'b0, 1'b0);
        run_matrix(hamming_pkg::mode_code_3x3, 1'b0, 1'b0, 1'b1);

        // Single-bit errors in element codewords
        repeat (2) run_matrix(hamming_pkg::mode_code_2x2, 1'b1, 1'b0, 1'b0);
        repeat (2) run_matrix(hamming_pkg::mode_code_3x3, 1'b1, 1'b0, 1'b0);

        // Single-bit errors in the mode codeword
        repeat (2) run_matrix(hamming_pkg::mode_code_2x2, 1'b0, 1'b1, 1'b0);
        repeat (2) run_matrix(hamming_pkg::mode_code_3x3, 1'b1, 1'b1, 1'b0);

        // Unknown modes give a zero word
        run_matrix(unknown_mode_code(), 1'b0, 1'b0, 1'b0);
        run_matrix(unknown_mode_code(), 1'b1, 1'b0, 1'b0);

        $display("%0d matrices, %0d results, %0d errors", n_matrices, n_results, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Each matrix takes under 30 cycles
    initial begin
        #(clk_period * (reset_cycles + 4 + n_planned * 30));
        $display("Watchdog expired before the test sequence finished");
        $display("%0d matrices, %0d results, %0d errors", n_matrices, n_results, n_errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== mdc.f ====
+incdir+verification
src/hamming_pkg.sv
src/det_pkg.sv
src/det_if.sv
src/hamming_corrector.sv
src/det_input_decode.sv
src/det_engine.sv
src/det_result_pack.sv
src/mdc_top.sv
verification/mdc_tb.sv
